/* all.f */
isa_pkg.sv
core_cfg_pkg.sv
fetch_if.sv
issue_if.sv
fetch_unit.sv
inst_queue.sv
reg_file.sv
exec_unit.sv
core_top.sv
core_props.sv
tb_core_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_core_top -f all.f > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/Vtb_core_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "PASS: all tests" sim.log && ! grep -q "FAIL: see errors above" sim.log || exit 1

/* tb_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_core_top;
    import isa_pkg::*;
    import core_cfg_pkg::*;

    localparam int unsigned PROG_LEN   = 64;
    localparam int unsigned RESET_CYC  = 16;
    // worst case is a 31 bit shift per instruction
    localparam int unsigned MAX_CYCLES = RESET_CYC + PROG_LEN * 33 + 50;

    logic      clk_i;
    logic      rst_n_i;
    logic      rom_ce_o;
    word_t     rom_addr_o;
    word_t     rom_data_i;
    logic      retire_valid_o;
    word_t     retire_pc_o;
    logic      retire_we_o;
    reg_addr_t retire_rd_o;
    word_t     retire_data_o;

    word_t       prog [PROG_LEN];
    logic        exp_we [PROG_LEN];
    reg_addr_t   exp_rd [PROG_LEN];
    word_t       exp_data [PROG_LEN];
    logic [31:0] lfsr;
    int unsigned cycles;
    int unsigned retired;
    int unsigned passed;
    int unsigned failed;
    int unsigned prop_fails;

    core_top DUT (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rom_ce_o       (rom_ce_o),
        .rom_addr_o     (rom_addr_o),
        .rom_data_i     (rom_data_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    bind core_top core_props #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_props (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rom_ce_o       (rom_ce_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o)
    );

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // registers limited to x0..x7 so results feed each other
    function automatic word_t make_inst();
        logic [3:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        word_t      w;
        kind = 4'(rand_bits(4));
        rd   = 5'(rand_bits(3));
        rs1  = 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        case (kind)
            4'd3:         w = {20'(rand_bits(20)), rd, 7'h37};
            4'd4:         w = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
            4'd5:         w = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
            4'd6:         w = {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
            4'd7:         w = {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
            4'd8:         w = {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
            4'd9, 4'd10:  w = {7'h00, 5'(rand_bits(5)), rs1, 3'b001, rd, 7'h13};
            4'd11, 4'd12: w = {7'h00, 5'(rand_bits(5)), rs1, 3'b101, rd, 7'h13};
            4'd13:        w = {25'(rand_bits(25)), 7'h0b};
            default:      w = {12'(rand_bits(12)), rs1, 3'b000, rd, 7'h13};
        endcase
        return w;
    endfunction

    // architectural model giving one expected retire record per word
    task automatic run_model();
        word_t      regs [32];
        word_t      w;
        word_t      a;
        word_t      r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w  = prog[i];
            f3 = w[14:12];
            f7 = w[31:25];
            a  = regs[w[19:15]];
            ok = 1'b1;
            r  = '0;
            if (w[6:0] == 7'h37) begin
                r = {w[31:12], 12'h000};
            end else if ((w[6:0] == 7'h13) && (f3 == 3'b000)) begin
                r = a + {{20{w[31]}}, w[31:20]};
            end else if ((w[6:0] == 7'h13) && (f3 == 3'b001) && (f7 == 7'h00)) begin
                r = a << w[24:20];
            end else if ((w[6:0] == 7'h13) && (f3 == 3'b101) && (f7 == 7'h00)) begin
                r = a >> w[24:20];
            end else if ((w[6:0] == 7'h33) && (f7 == 7'h20) && (f3 == 3'b000)) begin
                r = a - regs[w[24:20]];
            end else if ((w[6:0] == 7'h33) && (f7 == 7'h00)) begin
                case (f3)
                    3'b000:  r = a + regs[w[24:20]];
                    3'b100:  r = a ^ regs[w[24:20]];
                    3'b110:  r = a | regs[w[24:20]];
                    3'b111:  r = a & regs[w[24:20]];
                    default: ok = 1'b0;
                endcase
            end else begin
                ok = 1'b0;
            end
            exp_rd[i]   = w[11:7];
            exp_we[i]   = ok && (w[11:7] != 5'd0);
            exp_data[i] = r;
            if (exp_we[i]) begin
                regs[w[11:7]] = r;
            end
        end
    endtask

    // illegal words past the program that vary with the address
    function automatic word_t rom_word(input word_t addr);
        word_t off;
        off = addr - DEFAULT_RESET_PC;
        if (off < PROG_LEN * 4) begin
            return prog[off[7:2]];
        end
        return {25'(addr ^ (addr >> 7)), 7'h0b};
    endfunction

    task automatic check_retire(input int unsigned idx);
        int unsigned errs;
        string       name;
        word_t       exp_pc;
        errs   = 0;
        name   = $sformatf("inst_%0d (%h)", idx, prog[idx]);
        exp_pc = DEFAULT_RESET_PC + 4 * idx;
        assert (retire_pc_o == exp_pc) else begin
            $display("[ERROR] %s pc: expected %h, actual %h", name, exp_pc, retire_pc_o);
            errs++;
        end
        assert (retire_rd_o == exp_rd[idx]) else begin
            $display("[ERROR] %s rd: expected %0d, actual %0d", name, exp_rd[idx], retire_rd_o);
            errs++;
        end
        assert (retire_we_o == exp_we[idx]) else begin
            $display("[ERROR] %s we: expected %b, actual %b", name, exp_we[idx], retire_we_o);
            errs++;
        end
        if (exp_we[idx]) begin
            assert (retire_data_o == exp_data[idx]) else begin
                $display("[ERROR] %s data: expected %h, actual %h", name, exp_data[idx],
                         retire_data_o);
                errs++;
            end
        end
        if (errs == 0) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: failed", name);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
    end

    // ROM answers one cycle after the request
    always @(posedge clk_i) begin
        if (rom_ce_o) begin
            rom_data_i <= rom_word(rom_addr_o);
        end
    end

    always @(posedge clk_i) begin
        if (rst_n_i && retire_valid_o && (retired < PROG_LEN)) begin
            check_retire(retired);
            retired++;
        end
    end

    initial begin
        rst_n_i    = 1'b0;
        rom_data_i = '0;
        cycles     = 0;
        retired    = 0;
        passed     = 0;
        failed     = 0;
        lfsr       = 32'hf9a7_f45b;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = make_inst();
        end
        // shift amount extremes
        prog[PROG_LEN-2] = {7'h00, 5'd0, 5'd1, 3'b001, 5'd3, 7'h13};
        prog[PROG_LEN-1] = {7'h00, 5'd31, 5'd2, 3'b101, 5'd4, 7'h13};
        run_model();

        repeat (RESET_CYC) @(posedge clk_i);
        rst_n_i <= 1'b1;

        while ((retired < PROG_LEN) && (cycles < MAX_CYCLES)) begin
            @(negedge clk_i);
        end
        if (retired < PROG_LEN) begin
            $display("timeout: only %0d of %0d instructions retired within %0d cycles",
                     retired, PROG_LEN, MAX_CYCLES);
        end
        prop_fails = DUT.u_props.fail_count;
        $display("tests %0d, passed %0d, failed %0d, protocol assertion failures %0d",
                 PROG_LEN, passed, failed, prop_fails);
        if ((failed == 0) && (prop_fails == 0) && (retired == PROG_LEN)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* core_props.sv */
`timescale 1ns/100ps
`default_nettype none

module core_props #(
    parameter int unsigned    QUEUE_DEPTH = core_cfg_pkg::DEFAULT_QUEUE_DEPTH,
    parameter isa_pkg::word_t RESET_PC    = core_cfg_pkg::DEFAULT_RESET_PC
) (
    input logic           clk_i,
    input logic           rst_n_i,
    input logic           rom_ce_o,
    input logic           retire_valid_o,
    input isa_pkg::word_t retire_pc_o
);
    import isa_pkg::*;

    int unsigned fail_count = 0;
    int          inflight_q;
    word_t       next_pc_q;

    // words requested but not yet retired, and the pc of the next retire
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inflight_q <= 0;
            next_pc_q  <= RESET_PC;
        end else begin
            inflight_q <= inflight_q + int'(rom_ce_o) - int'(retire_valid_o);
            if (retire_valid_o) begin
                next_pc_q <= next_pc_q + 32'd4;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> (!rom_ce_o && !retire_valid_o))
    else begin
        $error("ROM request or retire during reset or in the cycle after it");
        fail_count++;
    end

    // queue plus the one instruction held in the shifter
    inflight_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        inflight_q <= int'(QUEUE_DEPTH) + 1)
    else begin
        $error("more words requested than the credits allow");
        fail_count++;
    end

    pc_in_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_valid_o |-> (retire_pc_o == next_pc_q))
    else begin
        $error("retire pc out of sequence");
        fail_count++;
    end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_top #(
    parameter int unsigned    QUEUE_DEPTH = core_cfg_pkg::DEFAULT_QUEUE_DEPTH,
    parameter isa_pkg::word_t RESET_PC    = core_cfg_pkg::DEFAULT_RESET_PC
) (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // instruction ROM
    output logic               rom_ce_o,
    output isa_pkg::word_t     rom_addr_o,
    input  isa_pkg::word_t     rom_data_i,

    // retire trace
    output logic               retire_valid_o,
    output isa_pkg::word_t     retire_pc_o,
    output logic               retire_we_o,
    output isa_pkg::reg_addr_t retire_rd_o,
    output isa_pkg::word_t     retire_data_o
);

    fetch_if fetch_link ();
    issue_if issue_link ();

    fetch_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_fetch (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .rom_data_i (rom_data_i),
        .link       (fetch_link.sender)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push    (fetch_link.receiver),
        .pop     (issue_link.source)
    );

    exec_unit u_exec (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue          (issue_link.sink),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

`default_nettype wire

/* exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  logic               clk_i,
    input  logic               rst_n_i,
    issue_if.sink              issue,
    output logic               retire_valid_o,
    output isa_pkg::word_t     retire_pc_o,
    output logic               retire_we_o,
    output isa_pkg::reg_addr_t retire_rd_o,
    output isa_pkg::word_t     retire_data_o
);
    import isa_pkg::*;
    import core_cfg_pkg::*;

    exec_state_e state_q;

    word_t      inst;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] shamt;

    alu_op_e alu_op;
    word_t   imm;
    logic    use_imm;
    logic    legal;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   op_b;
    word_t   alu_result;

    logic take;
    logic is_shift;
    logic start_shift;

    word_t      shift_val_q;
    logic [4:0] shift_cnt_q;
    logic       shift_left_q;
    reg_addr_t  shift_rd_q;
    logic       shift_we_q;
    word_t      shift_pc_q;
    word_t      shift_next;
    logic       shift_done;

    logic      done;
    logic      done_we;
    reg_addr_t done_rd;
    word_t     done_data;
    word_t     done_pc;

    assign inst   = issue.head.inst;
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign shamt  = inst[24:20];

    always_comb begin
        alu_op  = ALU_ADD;
        imm     = {{20{inst[31]}}, inst[31:20]};
        use_imm = 1'b1;
        legal   = 1'b0;
        case (opcode_e'(inst[6:0]))
            OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        legal = 1'b1;
                    end
                    F3_SLL: begin
                        alu_op = ALU_SLL;
                        legal  = (funct7 == F7_BASE);
                    end
                    F3_SRL: begin
                        alu_op = ALU_SRL;
                        legal  = (funct7 == F7_BASE);
                    end
                    default: begin
                        legal = 1'b0;
                    end
                endcase
            end
            OP: begin
                use_imm = 1'b0;
                if (funct7 == F7_BASE) begin
                    legal = 1'b1;
                    case (funct3)
                        F3_ADD_SUB: alu_op = ALU_ADD;
                        F3_XOR:     alu_op = ALU_XOR;
                        F3_OR:      alu_op = ALU_OR;
                        F3_AND:     alu_op = ALU_AND;
                        default:    legal = 1'b0;
                    endcase
                end else if ((funct7 == F7_ALT) && (funct3 == F3_ADD_SUB)) begin
                    alu_op = ALU_SUB;
                    legal  = 1'b1;
                end
            end
            LUI: begin
                alu_op = ALU_PASS;
                imm    = {inst[31:12], 12'b0};
                legal  = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign op_b = use_imm ? imm : rs2_data;

    // shifts by zero end here, longer ones go to the serial shifter
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = rs1_data + op_b;
            ALU_SUB:  alu_result = rs1_data - op_b;
            ALU_AND:  alu_result = rs1_data & op_b;
            ALU_OR:   alu_result = rs1_data | op_b;
            ALU_XOR:  alu_result = rs1_data ^ op_b;
            ALU_PASS: alu_result = op_b;
            default:  alu_result = rs1_data;
        endcase
    end

    assign take        = (state_q == EX_RUN) && issue.head_valid;
    assign is_shift    = legal && ((alu_op == ALU_SLL) || (alu_op == ALU_SRL));
    assign start_shift = take && is_shift && (shamt != '0);
    assign issue.take  = take;

    // one bit per cycle
    assign shift_next = shift_left_q ? {shift_val_q[XLEN-2:0], 1'b0}
                                     : {1'b0, shift_val_q[XLEN-1:1]};
    assign shift_done = (state_q == EX_SHIFT) && (shift_cnt_q == 5'd1);

    always_comb begin
        if (state_q == EX_SHIFT) begin
            done      = shift_done;
            done_we   = shift_we_q;
            done_rd   = shift_rd_q;
            done_data = shift_next;
            done_pc   = shift_pc_q;
        end else begin
            done      = take && !start_shift;
            done_we   = legal && (rd != '0);
            done_rd   = rd;
            done_data = alu_result;
            done_pc   = issue.head.pc;
        end
    end

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (inst[19:15]),
        .rs2_addr_i (inst[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (done && done_we),
        .waddr_i    (done_rd),
        .wdata_i    (done_data)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q        <= EX_RUN;
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= done;
            case (state_q)
                EX_RUN: begin
                    if (start_shift) begin
                        state_q <= EX_SHIFT;
                    end
                end
                EX_SHIFT: begin
                    if (shift_done) begin
                        state_q <= EX_RUN;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_shift) begin
            shift_val_q  <= rs1_data;
            shift_cnt_q  <= shamt;
            shift_left_q <= (alu_op == ALU_SLL);
            shift_rd_q   <= rd;
            shift_we_q   <= (rd != '0);
            shift_pc_q   <= issue.head.pc;
        end else if (state_q == EX_SHIFT) begin
            shift_val_q <= shift_next;
            shift_cnt_q <= shift_cnt_q - 5'd1;
        end
    end

    // retire record
    always_ff @(posedge clk_i) begin
        if (done) begin
            retire_pc_o   <= done_pc;
            retire_we_o   <= done_we;
            retire_rd_o   <= done_rd;
            retire_data_o <= done_data;
        end
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  isa_pkg::reg_addr_t rs1_addr_i,
    input  isa_pkg::reg_addr_t rs2_addr_i,
    output isa_pkg::word_t     rs1_data_o,
    output isa_pkg::word_t     rs2_data_o,
    input  logic               we_i,
    input  isa_pkg::reg_addr_t waddr_i,
    input  isa_pkg::word_t     wdata_i
);
    import isa_pkg::*;

    word_t regs_q [32];

    // x0 is cleared here and never written again
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* inst_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_queue #(
    parameter int unsigned QUEUE_DEPTH = core_cfg_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    fetch_if.receiver push,
    issue_if.source   pop
);
    import core_cfg_pkg::*;

    localparam int unsigned PW = $clog2(QUEUE_DEPTH);
    localparam int unsigned CW = $clog2(QUEUE_DEPTH + 1);

    fetch_entry_t  mem_q [QUEUE_DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          credit_q;

    // sender holds a credit for every push, so there is always room
    always_ff @(posedge clk_i) begin
        if (push.push_valid) begin
            mem_q[wr_ptr_q] <= push.entry;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            wr_ptr_q <= wr_ptr_q + PW'(push.push_valid);
            rd_ptr_q <= rd_ptr_q + PW'(pop.take);
            count_q  <= count_q + CW'(push.push_valid) - CW'(pop.take);
            credit_q <= pop.take;
        end
    end

    assign pop.head_valid     = (count_q != '0);
    assign pop.head           = mem_q[rd_ptr_q];
    assign push.credit_return = credit_q;

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
    parameter int unsigned    QUEUE_DEPTH = core_cfg_pkg::DEFAULT_QUEUE_DEPTH,
    parameter isa_pkg::word_t RESET_PC    = core_cfg_pkg::DEFAULT_RESET_PC
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    output logic           rom_ce_o,
    output isa_pkg::word_t rom_addr_o,
    input  isa_pkg::word_t rom_data_i,
    fetch_if.sender        link
);
    import isa_pkg::*;

    localparam int unsigned CW = $clog2(QUEUE_DEPTH + 1);

    logic          run_q;
    logic [CW-1:0] credits_q;
    word_t         pc_q;
    logic          req_valid_q;
    word_t         req_pc_q;

    // first request goes out one cycle after reset is released
    assign rom_ce_o   = run_q && (credits_q != '0);
    assign rom_addr_o = pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q       <= 1'b0;
            credits_q   <= CW'(QUEUE_DEPTH);
            pc_q        <= RESET_PC;
            req_valid_q <= 1'b0;
        end else begin
            run_q       <= 1'b1;
            // spend one per request, get one back per take
            credits_q   <= credits_q - CW'(rom_ce_o) + CW'(link.credit_return);
            req_valid_q <= rom_ce_o;
            if (rom_ce_o) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    // pc of the word that the ROM returns next cycle
    always_ff @(posedge clk_i) begin
        if (rom_ce_o) begin
            req_pc_q <= pc_q;
        end
    end

    assign link.push_valid = req_valid_q;
    assign link.entry      = '{pc: req_pc_q, inst: rom_data_i};

endmodule

`default_nettype wire

/* issue_if.sv */
`timescale 1ns/100ps
`default_nettype none

// queue head to execute, entry leaves on take
interface issue_if;
    import core_cfg_pkg::*;

    logic         head_valid;
    fetch_entry_t head;
    logic         take;

    modport source (output head_valid, output head, input take);

    modport sink (input head_valid, input head, output take);

endinterface

`default_nettype wire

/* fetch_if.sv */
`timescale 1ns/100ps
`default_nettype none

// credit based link, fetch to queue
interface fetch_if;
    import core_cfg_pkg::*;

    logic         push_valid;
    fetch_entry_t entry;
    logic         credit_return;

    modport sender (output push_valid, output entry, input credit_return);

    modport receiver (input push_valid, input entry, output credit_return);

endinterface

`default_nettype wire

/* core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

    // one queue entry: fetch address and the word read there
    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_entry_t;

    typedef enum logic {
        EX_RUN,
        EX_SHIFT
    } exec_state_e;

    localparam int unsigned    DEFAULT_QUEUE_DEPTH = 4;
    localparam isa_pkg::word_t DEFAULT_RESET_PC    = 32'h0000_0000;

endpackage

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS
    } alu_op_e;

    // funct3 / funct7 field values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

endpackage

`default_nettype wire
